//--- Bender.yml
package:
  name: axi_write_mux

sources:
  - files:
      - rtl/axi_types_pkg.sv
      - rtl/mux_cfg_pkg.sv
      - rtl/aw_arbiter.sv
      - rtl/w_route_fifo.sv
      - rtl/w_mux.sv
      - rtl/b_demux.sv
      - rtl/axi_write_mux.sv
  - target: test
    files:
      - bench/axi_write_mux_properties.sv
      - bench/tb_axi_write_mux.sv

//--- bench/axi_write_mux_properties.sv
/*
 * Concurrent assertions on the AW arbiter, bound into every aw_arbiter
 * instance. Covers lock-in stability, route FIFO overflow and grant shape.
 */
`timescale 1ns/1ps

module axi_write_mux_properties
  import axi_types_pkg::*;
  import mux_cfg_pkg::*;
#(
  parameter int unsigned NUM_PORTS = 4
) (
  input logic                 clk_i,
  input logic                 reset_i,
  input arb_state_t           state_q,
  input logic [NUM_PORTS-1:0] slv_aw_valid_i,
  input logic [NUM_PORTS-1:0] slv_aw_ready_o,
  input id_t                  mst_aw_id_o,
  input addr_t                mst_aw_addr_o,
  input len_t                 mst_aw_len_o,
  input logic                 mst_aw_valid_o,
  input logic                 mst_aw_ready_i,
  input logic                 route_full_i,
  input logic                 route_push_o
);

  // Offered address holds until the downstream takes it
  aw_hold_a: assert property (@(posedge clk_i) disable iff (reset_i)
    mst_aw_valid_o && !mst_aw_ready_i |=> mst_aw_valid_o && $stable(mst_aw_id_o)
      && $stable(mst_aw_addr_o) && $stable(mst_aw_len_o))
    else $error("AW address changed or dropped before its transfer");

  // A waiting address was offered while the FIFO still had room
  locked_not_full_a: assert property (@(posedge clk_i) disable iff (reset_i)
    state_q == ARB_LOCKED |-> !route_full_i)
    else $error("route FIFO full while an address is locked");

  no_push_full_a: assert property (@(posedge clk_i) disable iff (reset_i)
    route_full_i |-> !route_push_o)
    else $error("route push while the route FIFO is full");

  ready_onehot_a: assert property (@(posedge clk_i) disable iff (reset_i)
    $onehot0(slv_aw_ready_o) && ((slv_aw_ready_o & ~slv_aw_valid_i) == '0))
    else $error("AW ready not one-hot or raised for a port without a request");

endmodule

bind aw_arbiter axi_write_mux_properties #(
  .NUM_PORTS      ( NUM_PORTS      )
) aw_props_inst (
  .clk_i          ( clk_i          ),
  .reset_i        ( reset_i        ),
  .state_q        ( state_q        ),
  .slv_aw_valid_i ( slv_aw_valid_i ),
  .slv_aw_ready_o ( slv_aw_ready_o ),
  .mst_aw_id_o    ( mst_aw_id_o    ),
  .mst_aw_addr_o  ( mst_aw_addr_o  ),
  .mst_aw_len_o   ( mst_aw_len_o   ),
  .mst_aw_valid_o ( mst_aw_valid_o ),
  .mst_aw_ready_i ( mst_aw_ready_i ),
  .route_full_i   ( route_full_i   ),
  .route_push_o   ( route_push_o   )
);

//--- bench/tb_axi_write_mux.sv
/*
 * Directed testbench for the write-only AXI4 multiplexer. Acts as the four
 * upstream masters and the downstream slave, checks each channel's output.
 */
`timescale 1ns/1ps

module tb_axi_write_mux
  import axi_types_pkg::*;
  import mux_cfg_pkg::*;
();

  localparam int NUM_PORTS       = 4;
  localparam int MAX_W_TRANS     = 4;
  localparam int CLK_PERIOD      = 100;
  localparam int NUM_TESTS       = 6;
  localparam int TEST_CYCLES     = 40;
  localparam int WATCHDOG_CYCLES = NUM_TESTS * TEST_CYCLES + 50;

  logic                   clk_i;
  logic                   reset_i;
  id_t    [NUM_PORTS-1:0] slv_aw_id_i;
  addr_t  [NUM_PORTS-1:0] slv_aw_addr_i;
  len_t   [NUM_PORTS-1:0] slv_aw_len_i;
  logic   [NUM_PORTS-1:0] slv_aw_valid_i;
  logic   [NUM_PORTS-1:0] slv_aw_ready_o;
  data_t  [NUM_PORTS-1:0] slv_w_data_i;
  strb_t  [NUM_PORTS-1:0] slv_w_strb_i;
  logic   [NUM_PORTS-1:0] slv_w_last_i;
  logic   [NUM_PORTS-1:0] slv_w_valid_i;
  logic   [NUM_PORTS-1:0] slv_w_ready_o;
  id_t    [NUM_PORTS-1:0] slv_b_id_o;
  bresp_t [NUM_PORTS-1:0] slv_b_resp_o;
  logic   [NUM_PORTS-1:0] slv_b_valid_o;
  logic   [NUM_PORTS-1:0] slv_b_ready_i;
  id_t                    mst_aw_id_o;
  addr_t                  mst_aw_addr_o;
  len_t                   mst_aw_len_o;
  logic                   mst_aw_valid_o;
  logic                   mst_aw_ready_i;
  data_t                  mst_w_data_o;
  strb_t                  mst_w_strb_o;
  logic                   mst_w_last_o;
  logic                   mst_w_valid_o;
  logic                   mst_w_ready_i;
  id_t                    mst_b_id_i;
  bresp_t                 mst_b_resp_i;
  logic                   mst_b_valid_i;
  logic                   mst_b_ready_o;

  // Per-port stimulus filled once from the seeded generator
  integer seed = 32'h480b_2ce5;
  data_t  beat_data [NUM_PORTS][8];
  strb_t  beat_strb [NUM_PORTS][8];
  addr_t  port_addr [NUM_PORTS];
  int     errors = 0;
  int     checks = 0;
  int     tests  = 0;

  axi_write_mux #(
    .NUM_PORTS   ( NUM_PORTS   ),
    .MAX_W_TRANS ( MAX_W_TRANS )
  ) axi_write_mux_inst (.*);

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  initial begin : watchdog
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Watchdog expired after %0d cycles, a handshake never completed", WATCHDOG_CYCLES);
    $display("TB FAILED");
    $finish;
  end

  // ----------------------------------------------------------------------
  // Compare tasks
  // ----------------------------------------------------------------------
  task automatic compare_aw(input id_t id, input addr_t addr, input len_t len);
    checks++;
    if (mst_aw_id_o !== id || mst_aw_addr_o !== addr || mst_aw_len_o !== len) begin
      errors++;
      $display("FAILED at %t: AW id %h addr %h len %h, expected id %h addr %h len %h",
               $time, mst_aw_id_o, mst_aw_addr_o, mst_aw_len_o, id, addr, len);
    end
  endtask

  task automatic compare_w(input data_t data, input strb_t strb, input logic last);
    checks++;
    if (mst_w_data_o !== data || mst_w_strb_o !== strb || mst_w_last_o !== last) begin
      errors++;
      $display("FAILED at %t: W data %h strb %h last %b, expected data %h strb %h last %b",
               $time, mst_w_data_o, mst_w_strb_o, mst_w_last_o, data, strb, last);
    end
  endtask

  task automatic compare_b(input port_idx_t port, input id_t id, input bresp_t resp);
    logic [NUM_PORTS-1:0] exp_valid;
    exp_valid       = '0;
    exp_valid[port] = 1'b1;
    checks++;
    if (slv_b_valid_o !== exp_valid || slv_b_id_o[port] !== id ||
        slv_b_resp_o[port] !== resp) begin
      errors++;
      $display("FAILED at %t: B valid %b id %h resp %h, expected valid %b id %h resp %h",
               $time, slv_b_valid_o, slv_b_id_o[port], slv_b_resp_o[port],
               exp_valid, id, resp);
    end
  endtask

  task automatic compare_flag(input logic got, input logic exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED at %t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  // ----------------------------------------------------------------------
  // Channel drivers and monitors
  // ----------------------------------------------------------------------
  // Port number in the top ID bits and a tag below
  function automatic id_t make_id(input int p, input int tag);
    return id_t'((p << ID_PORT_LSB) | (tag & ((1 << ID_PORT_LSB) - 1)));
  endfunction

  task automatic reset_dut();
    @(posedge clk_i);
    reset_i        <= 1'b1;
    slv_aw_valid_i <= '0;
    slv_w_valid_i  <= '0;
    slv_w_last_i   <= '0;
    slv_b_ready_i  <= '0;
    mst_aw_ready_i <= 1'b0;
    mst_w_ready_i  <= 1'b0;
    mst_b_valid_i  <= 1'b0;
    repeat (5) @(posedge clk_i);
    reset_i <= 1'b0;
  endtask

  // Hold one address on a port until its ready is seen
  task automatic aw_put(input int p, input id_t id, input addr_t addr, input len_t len);
    @(posedge clk_i);
    slv_aw_id_i[p]    <= id;
    slv_aw_addr_i[p]  <= addr;
    slv_aw_len_i[p]   <= len;
    slv_aw_valid_i[p] <= 1'b1;
    do @(negedge clk_i); while (!slv_aw_ready_o[p]);
    @(posedge clk_i);
    slv_aw_valid_i[p] <= 1'b0;
  endtask

  task automatic aw_take(input id_t id, input addr_t addr, input len_t len);
    do @(negedge clk_i); while (!(mst_aw_valid_o && mst_aw_ready_i));
    compare_aw(id, addr, len);
  endtask

  task automatic w_put(input int p, input int beats);
    for (int b = 0; b < beats; b++) begin
      @(posedge clk_i);
      slv_w_data_i[p]  <= beat_data[p][b];
      slv_w_strb_i[p]  <= beat_strb[p][b];
      slv_w_last_i[p]  <= (b == beats - 1);
      slv_w_valid_i[p] <= 1'b1;
      do @(negedge clk_i); while (!slv_w_ready_o[p]);
    end
    @(posedge clk_i);
    slv_w_valid_i[p] <= 1'b0;
    slv_w_last_i[p]  <= 1'b0;
  endtask

  task automatic w_take(input int p, input int beats);
    for (int b = 0; b < beats; b++) begin
      do @(negedge clk_i); while (!(mst_w_valid_o && mst_w_ready_i));
      compare_w(beat_data[p][b], beat_strb[p][b], logic'(b == beats - 1));
    end
  endtask

  // All ports request together and are granted in port order
  task automatic aw_all_ports(input len_t len);
    fork
      aw_put(0, make_id(0, 1), port_addr[0], len);
      aw_put(1, make_id(1, 1), port_addr[1], len);
      aw_put(2, make_id(2, 1), port_addr[2], len);
      aw_put(3, make_id(3, 1), port_addr[3], len);
      for (int p = 0; p < NUM_PORTS; p++) begin
        aw_take(make_id(p, 1), port_addr[p], len);
      end
    join
  endtask

  task automatic finish_test(input string name, input int err0);
    tests++;
    if (errors == err0) begin
      $display("test %-16s ok", name);
    end else begin
      $display("test %-16s %0d error(s)", name, errors - err0);
    end
  endtask

  // ----------------------------------------------------------------------
  // Tests
  // ----------------------------------------------------------------------
  task automatic test_single_write();
    id_t    id;
    bresp_t resp;
    int     err0;
    err0 = errors;
    id   = make_id(2, 1);
    resp = bresp_t'($random(seed));
    reset_dut();
    mst_aw_ready_i <= 1'b1;
    mst_w_ready_i  <= 1'b1;
    fork
      aw_put(2, id, port_addr[2], len_t'(2));
      aw_take(id, port_addr[2], len_t'(2));
      w_put(2, 3);
      w_take(2, 3);
    join
    @(posedge clk_i);
    mst_b_id_i    <= id;
    mst_b_resp_i  <= resp;
    mst_b_valid_i <= 1'b1;
    slv_b_ready_i <= '1;
    @(negedge clk_i);
    compare_b(port_idx_t'(2), id, resp);
    compare_flag(mst_b_ready_o, 1'b1, "mst_b_ready_o with port 2 ready");
    @(posedge clk_i);
    mst_b_valid_i <= 1'b0;
    finish_test("single_write", err0);
  endtask

  // Port 0 asks again right after its grant and has to wait for ports 2 and 3
  task automatic test_round_robin();
    int err0;
    err0 = errors;
    reset_dut();
    mst_aw_ready_i <= 1'b1;
    mst_w_ready_i  <= 1'b1;
    fork
      begin
        aw_put(0, make_id(0, 1), port_addr[0], len_t'(0));
        aw_put(0, make_id(0, 2), port_addr[0], len_t'(0));
      end
      aw_put(1, make_id(1, 1), port_addr[1], len_t'(0));
      aw_put(2, make_id(2, 1), port_addr[2], len_t'(0));
      aw_put(3, make_id(3, 1), port_addr[3], len_t'(0));
      begin
        for (int p = 0; p < NUM_PORTS; p++) begin
          aw_take(make_id(p, 1), port_addr[p], len_t'(0));
        end
        aw_take(make_id(0, 2), port_addr[0], len_t'(0));
      end
      w_put(0, 1);
      w_take(0, 1);
    join
    finish_test("round_robin", err0);
  endtask

  // Port 1 joins after port 3 is chosen and would win without the lock
  task automatic test_lock_in();
    int err0;
    err0 = errors;
    reset_dut();
    fork
      aw_put(3, make_id(3, 2), port_addr[3], len_t'(5));
      begin
        @(posedge clk_i);
        aw_put(1, make_id(1, 2), port_addr[1], len_t'(6));
      end
      begin
        @(posedge clk_i);
        repeat (4) begin
          @(negedge clk_i);
          compare_flag(mst_aw_valid_o, 1'b1, "mst_aw_valid_o while locked");
          compare_aw(make_id(3, 2), port_addr[3], len_t'(5));
        end
        @(posedge clk_i);
        mst_aw_ready_i <= 1'b1;
        aw_take(make_id(3, 2), port_addr[3], len_t'(5));
        aw_take(make_id(1, 2), port_addr[1], len_t'(6));
      end
    join
    finish_test("lock_in", err0);
  endtask

  task automatic test_w_order();
    int err0;
    err0 = errors;
    reset_dut();
    mst_aw_ready_i <= 1'b1;
    mst_w_ready_i  <= 1'b1;
    fork
      begin
        aw_put(3, make_id(3, 0), port_addr[3], len_t'(3));
        aw_put(0, make_id(0, 0), port_addr[0], len_t'(1));
      end
      begin
        aw_take(make_id(3, 0), port_addr[3], len_t'(3));
        aw_take(make_id(0, 0), port_addr[0], len_t'(1));
      end
      w_put(3, 4);
      w_put(0, 2);
      begin
        w_take(3, 4);
        w_take(0, 2);
      end
    join
    finish_test("w_order", err0);
  endtask

  task automatic test_fifo_full();
    id_t   id5;
    addr_t addr5;
    int    err0;
    err0  = errors;
    id5   = make_id(0, 3);
    addr5 = $random(seed);
    reset_dut();
    mst_aw_ready_i <= 1'b1;
    mst_w_ready_i  <= 1'b1;
    aw_all_ports(len_t'(1));
    fork
      aw_put(0, id5, addr5, len_t'(0));
      begin
        repeat (4) begin
          @(negedge clk_i);
          compare_flag(mst_aw_valid_o, 1'b0, "mst_aw_valid_o with route FIFO full");
        end
        fork
          w_put(0, 2);
          w_take(0, 2);
        join
        aw_take(id5, addr5, len_t'(0));
      end
    join
    finish_test("fifo_full", err0);
  endtask

  task automatic test_b_backpressure();
    id_t    id;
    bresp_t resp;
    int     err0;
    err0 = errors;
    id   = make_id(1, 2);
    resp = bresp_t'($random(seed));
    reset_dut();
    mst_b_id_i    <= id;
    mst_b_resp_i  <= resp;
    mst_b_valid_i <= 1'b1;
    slv_b_ready_i <= 4'b1101;
    repeat (3) begin
      @(negedge clk_i);
      compare_flag(mst_b_ready_o, 1'b0, "mst_b_ready_o while port 1 stalls");
      compare_b(port_idx_t'(1), id, resp);
    end
    @(posedge clk_i);
    slv_b_ready_i[1] <= 1'b1;
    @(negedge clk_i);
    compare_flag(mst_b_ready_o, 1'b1, "mst_b_ready_o after port 1 ready");
    compare_b(port_idx_t'(1), id, resp);
    @(posedge clk_i);
    mst_b_valid_i <= 1'b0;
    finish_test("b_backpressure", err0);
  endtask

  initial begin
    $timeformat(-9, 0, " ns", 0);
    clk_i          = 1'b0;
    reset_i        = 1'b1;
    slv_aw_id_i    = '0;
    slv_aw_addr_i  = '0;
    slv_aw_len_i   = '0;
    slv_aw_valid_i = '0;
    slv_w_data_i   = '0;
    slv_w_strb_i   = '0;
    slv_w_last_i   = '0;
    slv_w_valid_i  = '0;
    slv_b_ready_i  = '0;
    mst_aw_ready_i = 1'b0;
    mst_w_ready_i  = 1'b0;
    mst_b_id_i     = '0;
    mst_b_resp_i   = '0;
    mst_b_valid_i  = 1'b0;
    for (int p = 0; p < NUM_PORTS; p++) begin
      port_addr[p] = $random(seed);
      for (int b = 0; b < 8; b++) begin
        beat_data[p][b] = $random(seed);
        beat_strb[p][b] = $random(seed);
      end
    end

    test_single_write();
    test_round_robin();
    test_lock_in();
    test_w_order();
    test_fifo_full();
    test_b_backpressure();

    $display("summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

//--- build.f
rtl/axi_types_pkg.sv
rtl/mux_cfg_pkg.sv
rtl/aw_arbiter.sv
rtl/w_route_fifo.sv
rtl/w_mux.sv
rtl/b_demux.sv
rtl/axi_write_mux.sv
bench/axi_write_mux_properties.sv
bench/tb_axi_write_mux.sv

//--- rtl/aw_arbiter.sv
/*
 * Round-robin arbiter for the AW channel with lock-in. The chosen address
 * is offered combinationally and held until the downstream accepts it;
 * each accepted grant is pushed into the W route FIFO.
 */
`timescale 1ns/1ps

module aw_arbiter
  import axi_types_pkg::*;
  import mux_cfg_pkg::*;
#(
  parameter int unsigned NUM_PORTS = 4
) (
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  id_t   [NUM_PORTS-1:0]   slv_aw_id_i,
  input  addr_t [NUM_PORTS-1:0]   slv_aw_addr_i,
  input  len_t  [NUM_PORTS-1:0]   slv_aw_len_i,
  input  logic  [NUM_PORTS-1:0]   slv_aw_valid_i,
  output logic  [NUM_PORTS-1:0]   slv_aw_ready_o,
  output id_t                     mst_aw_id_o,
  output addr_t                   mst_aw_addr_o,
  output len_t                    mst_aw_len_o,
  output logic                    mst_aw_valid_o,
  input  logic                    mst_aw_ready_i,
  input  logic                    route_full_i,
  output logic                    route_push_o,
  output port_idx_t               route_idx_o
);

  arb_state_t state_q;
  port_idx_t  lock_idx_q;
  port_idx_t  rr_ptr_q;
  port_idx_t  pick_idx;
  logic       pick_valid;
  port_idx_t  grant_idx;
  logic       aw_xfer;

  // First requesting port at or after the priority pointer
  always_comb begin : proc_pick
    int unsigned idx;
    pick_idx   = '0;
    pick_valid = 1'b0;
    for (int unsigned i = 0; i < NUM_PORTS; i++) begin
      idx = (rr_ptr_q + i) % NUM_PORTS;
      if (!pick_valid && slv_aw_valid_i[idx]) begin
        pick_valid = 1'b1;
        pick_idx   = port_idx_t'(idx);
      end
    end
  end

  // ----------------------------------------------------------------------
  // Grant and handshake
  // ----------------------------------------------------------------------
  // The FIFO cannot fill while locked, only this block pushes into it
  assign grant_idx      = (state_q == ARB_LOCKED) ? lock_idx_q : pick_idx;
  assign mst_aw_valid_o = (state_q == ARB_LOCKED) || (pick_valid && !route_full_i);
  assign aw_xfer        = mst_aw_valid_o && mst_aw_ready_i;

  assign mst_aw_id_o   = slv_aw_id_i[grant_idx];
  assign mst_aw_addr_o = slv_aw_addr_i[grant_idx];
  assign mst_aw_len_o  = slv_aw_len_i[grant_idx];

  always_comb begin : proc_ready
    slv_aw_ready_o = '0;
    if (aw_xfer) begin
      slv_aw_ready_o[grant_idx] = 1'b1;
    end
  end

  assign route_push_o = aw_xfer;
  assign route_idx_o  = grant_idx;

  // ----------------------------------------------------------------------
  // Lock-in FSM and priority pointer
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q    <= ARB_IDLE;
      lock_idx_q <= '0;
      rr_ptr_q   <= '0;
    end else begin
      case (state_q)
        ARB_IDLE: begin
          // Offered but not taken, hold this port
          if (mst_aw_valid_o && !mst_aw_ready_i) begin
            state_q    <= ARB_LOCKED;
            lock_idx_q <= pick_idx;
          end
        end
        ARB_LOCKED: begin
          if (mst_aw_ready_i) begin
            state_q <= ARB_IDLE;
          end
        end
        default: state_q <= ARB_IDLE;
      endcase
      if (aw_xfer) begin
        rr_ptr_q <= (grant_idx == NUM_PORTS - 1) ? '0 : port_idx_t'(grant_idx + 1'b1);
      end
    end
  end

endmodule

//--- rtl/axi_types_pkg.sv
/*
 * Field widths and vector types of the AXI4 write channels (AW, W, B).
 * Imported by every block that carries channel payload.
 */

package axi_types_pkg;

  // ----------------------------------------------------------------------
  // Field widths
  // ----------------------------------------------------------------------
  localparam int unsigned ID_W    = 4;
  localparam int unsigned ADDR_W  = 32;
  localparam int unsigned LEN_W   = 8;
  localparam int unsigned DATA_W  = 32;
  localparam int unsigned STRB_W  = DATA_W / 8;
  localparam int unsigned BRESP_W = 2;

  // Channel field types
  typedef logic [ID_W-1:0]    id_t;
  typedef logic [ADDR_W-1:0]  addr_t;
  typedef logic [LEN_W-1:0]   len_t;    // beats minus one
  typedef logic [DATA_W-1:0]  data_t;
  typedef logic [STRB_W-1:0]  strb_t;
  typedef logic [BRESP_W-1:0] bresp_t;

endpackage

//--- rtl/axi_write_mux.sv
/*
 * Write-only AXI4 multiplexer. Merges the AW, W and B channels of
 * NUM_PORTS upstream masters onto one downstream port.
 */
`timescale 1ns/1ps

module axi_write_mux
  import axi_types_pkg::*;
  import mux_cfg_pkg::*;
#(
  parameter int unsigned NUM_PORTS   = 4,
  parameter int unsigned MAX_W_TRANS = 8
) (
  input  logic                   clk_i,
  input  logic                   reset_i,
  // Upstream AW
  input  id_t    [NUM_PORTS-1:0] slv_aw_id_i,
  input  addr_t  [NUM_PORTS-1:0] slv_aw_addr_i,
  input  len_t   [NUM_PORTS-1:0] slv_aw_len_i,
  input  logic   [NUM_PORTS-1:0] slv_aw_valid_i,
  output logic   [NUM_PORTS-1:0] slv_aw_ready_o,
  // Upstream W
  input  data_t  [NUM_PORTS-1:0] slv_w_data_i,
  input  strb_t  [NUM_PORTS-1:0] slv_w_strb_i,
  input  logic   [NUM_PORTS-1:0] slv_w_last_i,
  input  logic   [NUM_PORTS-1:0] slv_w_valid_i,
  output logic   [NUM_PORTS-1:0] slv_w_ready_o,
  // Upstream B
  output id_t    [NUM_PORTS-1:0] slv_b_id_o,
  output bresp_t [NUM_PORTS-1:0] slv_b_resp_o,
  output logic   [NUM_PORTS-1:0] slv_b_valid_o,
  input  logic   [NUM_PORTS-1:0] slv_b_ready_i,
  // Downstream AW
  output id_t                    mst_aw_id_o,
  output addr_t                  mst_aw_addr_o,
  output len_t                   mst_aw_len_o,
  output logic                   mst_aw_valid_o,
  input  logic                   mst_aw_ready_i,
  // Downstream W
  output data_t                  mst_w_data_o,
  output strb_t                  mst_w_strb_o,
  output logic                   mst_w_last_o,
  output logic                   mst_w_valid_o,
  input  logic                   mst_w_ready_i,
  // Downstream B
  input  id_t                    mst_b_id_i,
  input  bresp_t                 mst_b_resp_i,
  input  logic                   mst_b_valid_i,
  output logic                   mst_b_ready_o
);

  // Route FIFO links the AW grant order to the W drain order
  logic      route_push;
  port_idx_t route_idx;
  logic      route_full;
  logic      route_empty;
  logic      route_pop;
  port_idx_t head_idx;

  // ----------------------------------------------------------------------
  // AW channel
  // ----------------------------------------------------------------------
  aw_arbiter #(
    .NUM_PORTS      ( NUM_PORTS      )
  ) aw_arbiter_inst (
    .clk_i          ( clk_i          ),
    .reset_i        ( reset_i        ),
    .slv_aw_id_i    ( slv_aw_id_i    ),
    .slv_aw_addr_i  ( slv_aw_addr_i  ),
    .slv_aw_len_i   ( slv_aw_len_i   ),
    .slv_aw_valid_i ( slv_aw_valid_i ),
    .slv_aw_ready_o ( slv_aw_ready_o ),
    .mst_aw_id_o    ( mst_aw_id_o    ),
    .mst_aw_addr_o  ( mst_aw_addr_o  ),
    .mst_aw_len_o   ( mst_aw_len_o   ),
    .mst_aw_valid_o ( mst_aw_valid_o ),
    .mst_aw_ready_i ( mst_aw_ready_i ),
    .route_full_i   ( route_full     ),
    .route_push_o   ( route_push     ),
    .route_idx_o    ( route_idx      )
  );

  w_route_fifo #(
    .MAX_W_TRANS ( MAX_W_TRANS )
  ) w_route_fifo_inst (
    .clk_i       ( clk_i       ),
    .reset_i     ( reset_i     ),
    .push_i      ( route_push  ),
    .push_idx_i  ( route_idx   ),
    .pop_i       ( route_pop   ),
    .head_idx_o  ( head_idx    ),
    .full_o      ( route_full  ),
    .empty_o     ( route_empty )
  );

  // ----------------------------------------------------------------------
  // W and B channels
  // ----------------------------------------------------------------------
  w_mux #(
    .NUM_PORTS     ( NUM_PORTS     )
  ) w_mux_inst (
    .slv_w_data_i  ( slv_w_data_i  ),
    .slv_w_strb_i  ( slv_w_strb_i  ),
    .slv_w_last_i  ( slv_w_last_i  ),
    .slv_w_valid_i ( slv_w_valid_i ),
    .slv_w_ready_o ( slv_w_ready_o ),
    .head_idx_i    ( head_idx      ),
    .route_empty_i ( route_empty   ),
    .mst_w_data_o  ( mst_w_data_o  ),
    .mst_w_strb_o  ( mst_w_strb_o  ),
    .mst_w_last_o  ( mst_w_last_o  ),
    .mst_w_valid_o ( mst_w_valid_o ),
    .mst_w_ready_i ( mst_w_ready_i ),
    .route_pop_o   ( route_pop     )
  );

  b_demux #(
    .NUM_PORTS     ( NUM_PORTS     )
  ) b_demux_inst (
    .mst_b_id_i    ( mst_b_id_i    ),
    .mst_b_resp_i  ( mst_b_resp_i  ),
    .mst_b_valid_i ( mst_b_valid_i ),
    .mst_b_ready_o ( mst_b_ready_o ),
    .slv_b_id_o    ( slv_b_id_o    ),
    .slv_b_resp_o  ( slv_b_resp_o  ),
    .slv_b_valid_o ( slv_b_valid_o ),
    .slv_b_ready_i ( slv_b_ready_i )
  );

endmodule

//--- rtl/b_demux.sv
/*
 * B channel demultiplexer. The response goes back to the port whose number
 * sits in the top bits of the write ID; that port's ready is returned.
 */
`timescale 1ns/1ps

module b_demux
  import axi_types_pkg::*;
  import mux_cfg_pkg::*;
#(
  parameter int unsigned NUM_PORTS = 4
) (
  input  id_t                    mst_b_id_i,
  input  bresp_t                 mst_b_resp_i,
  input  logic                   mst_b_valid_i,
  output logic                   mst_b_ready_o,
  output id_t    [NUM_PORTS-1:0] slv_b_id_o,
  output bresp_t [NUM_PORTS-1:0] slv_b_resp_o,
  output logic   [NUM_PORTS-1:0] slv_b_valid_o,
  input  logic   [NUM_PORTS-1:0] slv_b_ready_i
);

  port_idx_t b_port;

  // Upstream masters must place their port number here
  assign b_port = mst_b_id_i[ID_PORT_LSB +: PORT_IDX_W];

  // Payload is broadcast, only valid is steered
  for (genvar p = 0; p < NUM_PORTS; p++) begin : gen_b_copy
    assign slv_b_id_o[p]   = mst_b_id_i;
    assign slv_b_resp_o[p] = mst_b_resp_i;
  end

  always_comb begin : proc_b_valid
    slv_b_valid_o         = '0;
    slv_b_valid_o[b_port] = mst_b_valid_i;
  end

  assign mst_b_ready_o = slv_b_ready_i[b_port];

endmodule

//--- rtl/mux_cfg_pkg.sv
/*
 * Port numbering and arbiter state shared by the write multiplexer blocks.
 */

package mux_cfg_pkg;

  // Upper bound for the NUM_PORTS parameter
  localparam int unsigned MAX_PORTS  = 4;
  localparam int unsigned PORT_IDX_W = $clog2(MAX_PORTS);

  typedef logic [PORT_IDX_W-1:0] port_idx_t;

  // Port number sits in the top ID bits, i.e. id[3:2] for a 4 bit ID
  localparam int unsigned ID_PORT_LSB = 2;

  // Address arbiter lock-in control
  typedef enum logic {
    ARB_IDLE,
    ARB_LOCKED
  } arb_state_t;

endpackage

//--- rtl/w_mux.sv
/*
 * W channel multiplexer. Connects the port at the route FIFO head to the
 * downstream W channel and pops the FIFO on the last beat of the burst.
 */
`timescale 1ns/1ps

module w_mux
  import axi_types_pkg::*;
  import mux_cfg_pkg::*;
#(
  parameter int unsigned NUM_PORTS = 4
) (
  input  data_t [NUM_PORTS-1:0] slv_w_data_i,
  input  strb_t [NUM_PORTS-1:0] slv_w_strb_i,
  input  logic  [NUM_PORTS-1:0] slv_w_last_i,
  input  logic  [NUM_PORTS-1:0] slv_w_valid_i,
  output logic  [NUM_PORTS-1:0] slv_w_ready_o,
  input  port_idx_t             head_idx_i,
  input  logic                  route_empty_i,
  output data_t                 mst_w_data_o,
  output strb_t                 mst_w_strb_o,
  output logic                  mst_w_last_o,
  output logic                  mst_w_valid_o,
  input  logic                  mst_w_ready_i,
  output logic                  route_pop_o
);

  // Payload always follows the head port
  assign mst_w_data_o = slv_w_data_i[head_idx_i];
  assign mst_w_strb_o = slv_w_strb_i[head_idx_i];
  assign mst_w_last_o = slv_w_last_i[head_idx_i];

  always_comb begin : proc_w_hs
    mst_w_valid_o = 1'b0;
    slv_w_ready_o = '0;
    route_pop_o   = 1'b0;
    if (!route_empty_i) begin
      mst_w_valid_o             = slv_w_valid_i[head_idx_i];
      slv_w_ready_o[head_idx_i] = mst_w_ready_i;
      // Burst done, move to the next granted port
      route_pop_o = slv_w_valid_i[head_idx_i] && mst_w_ready_i && slv_w_last_i[head_idx_i];
    end
  end

endmodule

//--- rtl/w_route_fifo.sv
/*
 * FIFO of granted port numbers, one entry per accepted write address.
 * The head names the port whose W burst is drained next. No fall-through.
 */
`timescale 1ns/1ps

module w_route_fifo
  import mux_cfg_pkg::*;
#(
  parameter int unsigned MAX_W_TRANS = 8
) (
  input  logic      clk_i,
  input  logic      reset_i,
  input  logic      push_i,
  input  port_idx_t push_idx_i,
  input  logic      pop_i,
  output port_idx_t head_idx_o,
  output logic      full_o,
  output logic      empty_o
);

  localparam int unsigned PTR_W = (MAX_W_TRANS > 1) ? $clog2(MAX_W_TRANS) : 1;
  localparam int unsigned CNT_W = $clog2(MAX_W_TRANS + 1);

  typedef logic [PTR_W-1:0] ptr_t;
  typedef logic [CNT_W-1:0] cnt_t;

  port_idx_t mem_q [MAX_W_TRANS];
  ptr_t      wr_ptr_q;
  ptr_t      rd_ptr_q;
  cnt_t      count_q;
  logic      do_push;
  logic      do_pop;

  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;

  assign full_o     = (count_q == cnt_t'(MAX_W_TRANS));
  assign empty_o    = (count_q == '0);
  assign head_idx_o = mem_q[rd_ptr_q];

  // Storage
  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= push_idx_i;
    end
  end

  // ----------------------------------------------------------------------
  // Pointers and fill count
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == ptr_t'(MAX_W_TRANS - 1)) ? '0 : ptr_t'(wr_ptr_q + 1'b1);
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == ptr_t'(MAX_W_TRANS - 1)) ? '0 : ptr_t'(rd_ptr_q + 1'b1);
      end
      // Simultaneous push and pop leave the count alone
      case ({do_push, do_pop})
        2'b10:   count_q <= cnt_t'(count_q + 1'b1);
        2'b01:   count_q <= cnt_t'(count_q - 1'b1);
        default: count_q <= count_q;
      endcase
    end
  end

endmodule
